// File: hdl/audio_pkg.sv
// sample path constants shared by the mixer, the modulator and the config interface
// import with audio_pkg::* in the module header
`default_nettype none

package audio_pkg;

  // sample format
  localparam int SAMPLE_W = 15;  // signed sample width, default for DATA_W

  // volume scaling, sample * vol >>> 6
  localparam int VOL_W     = 7;   // covers 0..64
  localparam int VOL_MAX   = 64;  // unity gain
  localparam int VOL_SHIFT = 6;

  // modulator tick divider
  localparam int DIV_W = 8;

  // interpolation counter width, 16 ticks per sample
  localparam int INTERP_DEFAULT = 4;

  // sigma/delta word growth
  localparam int SD_GAIN_W   = 2;  // headroom for the x3 input gain
  localparam int SD_ACC1_W   = 2;  // extra bits, first integrator
  localparam int SD_ACC2_W   = 5;  // extra bits, second integrator
  localparam int SD_DITHER_W = 4;  // dither bits added before the quantizer

  // noise generators
  localparam int LFSR1_W = 24;
  localparam int LFSR2_W = 19;
  localparam logic [LFSR1_W-1:0] LFSR1_SEED = 24'h654321;
  localparam logic [LFSR2_W-1:0] LFSR2_SEED = 19'h12345;

  // the second lfsr is added into the first, so it has to be the narrower one
  localparam int LFSR_PAD_W = LFSR1_W - LFSR2_W;

endpackage

`default_nettype wire

// File: hdl/audio_reg_pkg.sv
// host register map of the audio output stage
// import with audio_reg_pkg::* in the module header
`default_nettype none

package audio_reg_pkg;

  localparam int REG_DATA_W = 8;

  typedef enum logic [1:0] {
    REG_VOL_L = 2'd0,  // left volume, 0..64
    REG_VOL_R = 2'd1,  // right volume, 0..64
    REG_CTRL  = 2'd2,  // bit 0 mute, bit 1 enable
    REG_DIV   = 2'd3   // tick every div+1 clocks
  } reg_addr_e;

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  localparam int CTRL_MUTE_BIT   = 0;
  localparam int CTRL_ENABLE_BIT = 1;

  // reset values
  localparam logic [REG_DATA_W-1:0] VOL_RESET  = 8'd64;
  localparam logic [REG_DATA_W-1:0] CTRL_RESET = 8'd2;  // enabled, not muted
  localparam logic [REG_DATA_W-1:0] DIV_RESET  = 8'd3;

endpackage

`default_nettype wire

// File: hdl/audio_cfg_if.sv
// configuration from the register block to the mixer
// regs side drives everything, user side only reads
`timescale 1ns/1ns
`default_nettype none

interface audio_cfg_if import audio_pkg::*; ();

  logic [VOL_W-1:0] vol_l;   // 0..64
  logic [VOL_W-1:0] vol_r;
  logic             mute;    // zeroes both channels
  logic             enable;  // gates the modulator tick
  logic [DIV_W-1:0] div;     // tick period minus one

  modport regs (
    output vol_l,
    output vol_r,
    output mute,
    output enable,
    output div
  );

  modport user (
    input vol_l,
    input vol_r,
    input mute,
    input enable,
    input div
  );

endinterface

`default_nettype wire

// File: hdl/audio_ctrl_regs.sv
// host register block: volumes, mute/enable and tick divider
// four-phase req/ack slave, ack one cycle after req, write lands on that same edge
`timescale 1ns/1ns
`default_nettype none

module audio_ctrl_regs import audio_pkg::*, audio_reg_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  reg_req,
  input  reg_op_e               reg_op,
  input  reg_addr_e             reg_addr,
  input  logic [REG_DATA_W-1:0] reg_wdata,
  output logic                  reg_ack,
  output logic [REG_DATA_W-1:0] reg_rdata,
  audio_cfg_if.regs             cfg
);

  logic                  access;  // new request, not yet acked
  logic [VOL_W-1:0]      vol_wr;  // clamped volume
  logic [REG_DATA_W-1:0] rd_val;

  assign access = reg_req && !reg_ack;

  // anything above unity gain is pinned at 64
  assign vol_wr = (reg_wdata > REG_DATA_W'(VOL_MAX)) ? VOL_W'(VOL_MAX)
                                                     : VOL_W'(reg_wdata);

  // read mux
  always_comb begin
    case (reg_addr)
      REG_VOL_L: rd_val = REG_DATA_W'(cfg.vol_l);
      REG_VOL_R: rd_val = REG_DATA_W'(cfg.vol_r);
      REG_CTRL: begin
        rd_val                  = '0;
        rd_val[CTRL_MUTE_BIT]   = cfg.mute;
        rd_val[CTRL_ENABLE_BIT] = cfg.enable;
      end
      REG_DIV:   rd_val = REG_DATA_W'(cfg.div);
      default:   rd_val = '0;
    endcase
  end

  // handshake and register writes
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_ack    <= 1'b0;
      cfg.vol_l  <= VOL_W'(VOL_RESET);
      cfg.vol_r  <= VOL_W'(VOL_RESET);
      cfg.mute   <= CTRL_RESET[CTRL_MUTE_BIT];
      cfg.enable <= CTRL_RESET[CTRL_ENABLE_BIT];
      cfg.div    <= DIV_W'(DIV_RESET);
    end else if (access) begin
      reg_ack <= 1'b1;
      if (reg_op == REG_WRITE) begin
        case (reg_addr)
          REG_VOL_L: cfg.vol_l <= vol_wr;
          REG_VOL_R: cfg.vol_r <= vol_wr;
          REG_CTRL: begin
            cfg.mute   <= reg_wdata[CTRL_MUTE_BIT];
            cfg.enable <= reg_wdata[CTRL_ENABLE_BIT];
          end
          REG_DIV:   cfg.div <= DIV_W'(reg_wdata);
          default:   ;
        endcase
      end
    end else if (!reg_req && reg_ack) begin
      reg_ack <= 1'b0;  // host released req
    end
  end

  // read data, held until the next read
  always_ff @(posedge clk) begin
    if (access && reg_op == REG_READ) begin
      reg_rdata <= rd_val;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sample_mixer.sv
// sample input stage: four-phase sample port, volume scaling and mute
// also divides the clock down to the modulator tick
`timescale 1ns/1ns
`default_nettype none

module sample_mixer import audio_pkg::*; #(
  parameter int DATA_W = SAMPLE_W
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     smp_req,
  input  logic signed [DATA_W-1:0] smp_left,
  input  logic signed [DATA_W-1:0] smp_right,
  output logic                     smp_ack,
  audio_cfg_if.user                cfg,
  output logic signed [DATA_W-1:0] ldatasum,
  output logic signed [DATA_W-1:0] rdatasum,
  output logic                     tick
);

  logic                     load;     // first cycle of a request
  logic signed [DATA_W-1:0] l_hold;   // scaled sample, left
  logic signed [DATA_W-1:0] r_hold;   // scaled sample, right
  logic [DIV_W-1:0]         div_cnt;  // clocks left to the next tick

  // sample * vol >>> 6
  // vol is at most 64, so the result always fits back into DATA_W
  function automatic logic signed [DATA_W-1:0] scale(
    input logic signed [DATA_W-1:0] smp,
    input logic [VOL_W-1:0]         vol
  );
    logic signed [DATA_W+VOL_W:0] prod;
    logic signed [DATA_W+VOL_W:0] shifted;
    prod    = smp * $signed({1'b0, vol});
    shifted = prod >>> VOL_SHIFT;
    return shifted[DATA_W-1:0];
  endfunction

  assign load = smp_req && !smp_ack;

  // sample port handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      smp_ack <= 1'b0;
    end else if (load) begin
      smp_ack <= 1'b1;
    end else if (!smp_req && smp_ack) begin
      smp_ack <= 1'b0;
    end
  end

  // holding registers, a new sample simply replaces the old one
  always_ff @(posedge clk) begin
    if (reset) begin
      l_hold <= '0;
      r_hold <= '0;
    end else if (load) begin
      l_hold <= scale(smp_left, cfg.vol_l);
      r_hold <= scale(smp_right, cfg.vol_r);
    end
  end

  // mute acts on the held value, so unmute restores the last sample
  assign ldatasum = cfg.mute ? '0 : l_hold;
  assign rdatasum = cfg.mute ? '0 : r_hold;

  // tick every div+1 clocks while enabled
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (!cfg.enable) begin
      div_cnt <= cfg.div;  // restart a full period on enable
      tick    <= 1'b0;
    end else if (div_cnt == '0) begin
      div_cnt <= cfg.div;
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sigma_delta_modulator.sv
// stereo linear interpolator and second order sigma/delta modulator
// all state advances on tick only; lfsr dither is shared by both channels
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_modulator import audio_pkg::*; #(
  parameter int DATA_W      = SAMPLE_W,
  parameter int INTERP_BITS = INTERP_DEFAULT
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     tick,
  input  logic signed [DATA_W-1:0] ldatasum,
  input  logic signed [DATA_W-1:0] rdatasum,
  output logic                     left,
  output logic                     right
);

  localparam int ID = INTERP_BITS;
  localparam int GW = DATA_W + SD_GAIN_W;  // gained input
  localparam int A1 = GW + SD_ACC1_W;      // first accumulator
  localparam int A2 = GW + SD_ACC2_W;      // second accumulator
  localparam int QW = A2 + 1;              // quantizer input

  // noise
  logic [LFSR1_W-1:0] lfsr1;
  logic [LFSR2_W-1:0] lfsr2;
  logic [LFSR1_W-1:0] seed_sum;
  logic [LFSR1_W-1:0] seed_prev;
  logic [LFSR1_W-1:0] seed_out;  // differenced, so high-pass
  logic [QW-1:0]      dither;

  // per channel, index 0 left, index 1 right
  logic [ID-1:0]        int_cnt;
  logic [DATA_W-1:0]    data_in   [2];
  logic [DATA_W-1:0]    data_cur  [2];
  logic [DATA_W-1:0]    data_prev [2];
  logic [DATA_W:0]      step      [2];
  logic [DATA_W+ID-1:0] data_int  [2];
  logic [DATA_W-1:0]    int_out   [2];
  logic [GW-1:0]        gain      [2];
  logic [GW-1:0]        er0       [2];
  logic [GW-1:0]        er0_prev  [2];
  logic [A1-1:0]        aca1      [2];
  logic [A1-1:0]        ac1       [2];
  logic [A2-1:0]        aca2      [2];
  logic [A2-1:0]        ac2       [2];
  logic [QW-1:0]        quant     [2];
  logic [1:0]           sd_out;

  assign data_in[0] = ldatasum;
  assign data_in[1] = rdatasum;

  // two lfsrs, each reseeded if it ever locks up at all ones
  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr1     <= LFSR1_SEED;
      lfsr2     <= LFSR2_SEED;
      seed_sum  <= '0;
      seed_prev <= '0;
      seed_out  <= '0;
    end else if (tick) begin
      if (&lfsr1) lfsr1 <= LFSR1_SEED;
      else lfsr1 <= {lfsr1[LFSR1_W-2:0], ~(lfsr1[23] ^ lfsr1[22] ^ lfsr1[21] ^ lfsr1[16])};
      if (&lfsr2) lfsr2 <= LFSR2_SEED;
      else lfsr2 <= {lfsr2[LFSR2_W-2:0],
                     ~(lfsr2[18] ^ lfsr2[17] ^ lfsr2[16] ^ lfsr2[13] ^ lfsr2[0])};
      seed_sum  <= lfsr1 + {{LFSR_PAD_W{1'b0}}, lfsr2};
      seed_prev <= seed_sum;
      seed_out  <= seed_sum - seed_prev;
    end
  end

  assign dither = {{(QW-SD_DITHER_W){seed_out[SD_DITHER_W-1]}}, seed_out[SD_DITHER_W-1:0]};

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      // slope of the current segment, one extra bit for the signed difference
      step[c] = {data_cur[c][DATA_W-1], data_cur[c]} - {data_prev[c][DATA_W-1], data_prev[c]};
      int_out[c] = data_int[c][DATA_W+ID-1:ID];

      // x3 as 2x + x
      gain[c] = ({{SD_GAIN_W{int_out[c][DATA_W-1]}}, int_out[c]} << 1)
              + {{SD_GAIN_W{int_out[c][DATA_W-1]}}, int_out[c]};

      quant[c] = {ac2[c][A2-1], ac2[c]} + dither;

      // quantizer sign selects +full scale or -full scale feedback
      er0[c] = quant[c][QW-1] ? {1'b1, {(GW-1){1'b0}}} : {1'b0, {(GW-1){1'b1}}};

      aca1[c] = {{SD_ACC1_W{gain[c][GW-1]}}, gain[c]}
              - {{SD_ACC1_W{er0[c][GW-1]}}, er0[c]} + ac1[c];
      aca2[c] = {{(SD_ACC2_W-SD_ACC1_W){aca1[c][A1-1]}}, aca1[c]}
              - {{SD_ACC2_W{er0[c][GW-1]}}, er0[c]}
              - {{(SD_ACC2_W+1){er0_prev[c][GW-1]}}, er0_prev[c][GW-1:1]}  // half of last error
              + ac2[c];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      int_cnt <= '0;
      sd_out  <= '0;
      for (int c = 0; c < 2; c++) begin
        data_cur[c]  <= '0;
        data_prev[c] <= '0;
        data_int[c]  <= '0;
        ac1[c]       <= '0;
        ac2[c]       <= '0;
        er0_prev[c]  <= '0;
      end
    end else if (tick) begin
      int_cnt <= int_cnt + 1'b1;
      for (int c = 0; c < 2; c++) begin
        if (int_cnt == '0) begin
          // new segment starts where the last one ended
          data_prev[c] <= data_cur[c];
          data_cur[c]  <= data_in[c];
          data_int[c]  <= {data_cur[c], {ID{1'b0}}};
        end else begin
          data_int[c] <= data_int[c] + {{(ID-1){step[c][DATA_W]}}, step[c]};
        end
        ac1[c]      <= aca1[c];
        ac2[c]      <= aca2[c];
        er0_prev[c] <= er0[c] + 1'b1;
        // silence gives a plain toggle instead of idle tones
        sd_out[c]   <= (gain[c] == '0) ? ~sd_out[c] : ~er0[c][GW-1];
      end
    end
  end

  assign left  = sd_out[0];
  assign right = sd_out[1];

endmodule

`default_nettype wire

// File: hdl/audio_out_top.sv
// audio output stage top level: register block, sample mixer and sigma/delta modulator
// host side is two four-phase req/ack ports, outputs are two one-bit streams
`timescale 1ns/1ns
`default_nettype none

module audio_out_top import audio_pkg::*, audio_reg_pkg::*; #(
  parameter int DATA_W      = SAMPLE_W,
  parameter int INTERP_BITS = INTERP_DEFAULT
) (
  input  logic                     clk,
  input  logic                     reset,
  // host register port
  input  logic                     reg_req,
  input  reg_op_e                  reg_op,
  input  reg_addr_e                reg_addr,
  input  logic [REG_DATA_W-1:0]    reg_wdata,
  output logic                     reg_ack,
  output logic [REG_DATA_W-1:0]    reg_rdata,
  // sample port
  input  logic                     smp_req,
  input  logic signed [DATA_W-1:0] smp_left,
  input  logic signed [DATA_W-1:0] smp_right,
  output logic                     smp_ack,
  // bitstreams
  output logic                     left,
  output logic                     right
);

  logic signed [DATA_W-1:0] ldatasum;
  logic signed [DATA_W-1:0] rdatasum;
  logic                     tick;  // modulator clock enable

  audio_cfg_if cfg ();

  audio_ctrl_regs i_regs (
    .clk       (clk),
    .reset     (reset),
    .reg_req   (reg_req),
    .reg_op    (reg_op),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_ack   (reg_ack),
    .reg_rdata (reg_rdata),
    .cfg       (cfg)
  );

  sample_mixer #(.DATA_W(DATA_W)) i_mixer (
    .clk       (clk),
    .reset     (reset),
    .smp_req   (smp_req),
    .smp_left  (smp_left),
    .smp_right (smp_right),
    .smp_ack   (smp_ack),
    .cfg       (cfg),
    .ldatasum  (ldatasum),
    .rdatasum  (rdatasum),
    .tick      (tick)
  );

  sigma_delta_modulator #(.DATA_W(DATA_W), .INTERP_BITS(INTERP_BITS)) i_sdm (
    .clk       (clk),
    .reset     (reset),
    .tick      (tick),
    .ldatasum  (ldatasum),
    .rdatasum  (rdatasum),
    .left      (left),
    .right     (right)
  );

endmodule

`default_nettype wire

// File: sim/tb_audio_out.sv
// testbench for the audio output stage
// drives both host ports, checks register readback, handshakes and bitstream density
`timescale 1ns/1ns
`default_nettype none

module tb_audio_out import audio_pkg::*, audio_reg_pkg::*;;

  localparam int    DATA_W     = SAMPLE_W;
  localparam int    CLK_PERIOD = 20;
  localparam int    HS_LIMIT   = 20;    // cycles to wait for ack
  localparam int    WINDOW     = 4096;  // ticks per density measurement
  localparam int    TOL        = WINDOW * 2 / 100;
  localparam int    SETTLE     = 40;    // ticks for the interpolator to reach a new sample
  localparam int    N_DENSITY  = 6;
  localparam int    DIV_RUN    = 3;     // divider during the density runs
  localparam int    DIV_CLOCKS = 1200;
  localparam longint TICK_WINDOWS = (N_DENSITY + 1) * (WINDOW + SETTLE) + 1000;
  localparam longint WATCHDOG_NS  = TICK_WINDOWS * (DIV_RUN + 1) * CLK_PERIOD * 3 / 2;

  logic                     clk;
  logic                     reset;
  logic                     reg_req;
  reg_op_e                  reg_op;
  reg_addr_e                reg_addr;
  logic [REG_DATA_W-1:0]    reg_wdata;
  logic                     reg_ack;
  logic [REG_DATA_W-1:0]    reg_rdata;
  logic                     smp_req;
  logic signed [DATA_W-1:0] smp_left;
  logic signed [DATA_W-1:0] smp_right;
  logic                     smp_ack;
  logic                     left;
  logic                     right;

  int          errors = 0;
  logic [31:0] lfsr_state = 32'h34840229;
  logic        meas_go = 1'b0;  // hands a density run to the checker
  string       meas_name;
  int          meas_exp_l;      // expected scaled samples
  int          meas_exp_r;

  audio_out_top #(.DATA_W(DATA_W), .INTERP_BITS(INTERP_DEFAULT)) i_dut (
    .clk       (clk),
    .reset     (reset),
    .reg_req   (reg_req),
    .reg_op    (reg_op),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_ack   (reg_ack),
    .reg_rdata (reg_rdata),
    .smp_req   (smp_req),
    .smp_left  (smp_left),
    .smp_right (smp_right),
    .smp_ack   (smp_ack),
    .left      (left),
    .right     (right)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // signed 13-bit sample, keeps the gained signal well inside full scale
  function automatic int rand_sample();
    logic [31:0] v;
    v = rand_bits(13);
    return v[12] ? int'(v) - 8192 : int'(v);
  endfunction

  // expected scaled sample
  function automatic int scaled_ref(input int smp, input int vol, input bit mute);
    if (mute) return 0;
    return (smp * vol) >>> 6;
  endfunction

  // ones expected in one window, density 1/2 + 3*s/2^17
  function automatic int density_ref(input int scaled);
    return WINDOW / 2 + (3 * scaled * WINDOW) / 131072;
  endfunction

  task automatic check_val(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic reg_access(input reg_op_e op, input reg_addr_e addr,
                            input logic [REG_DATA_W-1:0] wdata,
                            output logic [REG_DATA_W-1:0] rdata);
    int n;
    reg_op    = op;
    reg_addr  = addr;
    reg_wdata = wdata;
    reg_req   = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (!reg_ack && n < HS_LIMIT);
    if (!reg_ack) begin
      $display("register port: no ack within %0d cycles of req", HS_LIMIT);
      errors++;
    end else begin
      check_val("reg_ack_rise", 1, n);
    end
    rdata   = reg_rdata;  // valid while ack is high
    reg_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (reg_ack && n < HS_LIMIT);
    if (reg_ack) begin
      $display("register port: ack still high %0d cycles after req was released", HS_LIMIT);
      errors++;
    end else begin
      check_val("reg_ack_fall", 1, n);
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [REG_DATA_W-1:0] data);
    logic [REG_DATA_W-1:0] unused_rd;
    reg_access(REG_WRITE, addr, data, unused_rd);
  endtask

  task automatic check_reg(input string name, input reg_addr_e addr, input int exp);
    logic [REG_DATA_W-1:0] rd;
    reg_access(REG_READ, addr, '0, rd);
    check_val(name, exp, int'(rd));
  endtask

  task automatic smp_load(input int l, input int r);
    int n;
    smp_left  = DATA_W'(l);
    smp_right = DATA_W'(r);
    smp_req   = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (!smp_ack && n < HS_LIMIT);
    if (!smp_ack) begin
      $display("sample port: no ack within %0d cycles of req", HS_LIMIT);
      errors++;
    end else begin
      check_val("smp_ack_rise", 1, n);
    end
    smp_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (smp_ack && n < HS_LIMIT);
    if (smp_ack) begin
      $display("sample port: ack still high %0d cycles after req was released", HS_LIMIT);
      errors++;
    end else begin
      check_val("smp_ack_fall", 1, n);
    end
  endtask

  // counts ticks at the falling edge, returns aligned for driving
  task automatic wait_ticks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk);
      if (i_dut.tick) seen++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic check_toggle(input string name, input int n);
    logic prev_l;
    logic prev_r;
    int   seen;
    seen = 0;
    while (seen <= n) begin
      @(negedge clk);
      if (i_dut.tick) begin
        if (seen > 0) begin
          check_val({name, "_left"}, int'(!prev_l), int'(left));
          check_val({name, "_right"}, int'(!prev_r), int'(right));
        end
        prev_l = left;
        prev_r = right;
        seen++;
      end
    end
    @(posedge clk);
    #2;
  endtask

  // density checker, one window per request from the main process
  always begin
    int ones_l;
    int ones_r;
    int seen;
    int exp_l;
    int exp_r;
    wait (meas_go);
    ones_l = 0;
    ones_r = 0;
    seen   = 0;
    while (seen < WINDOW) begin
      @(negedge clk);
      if (i_dut.tick) begin
        ones_l += int'(left);
        ones_r += int'(right);
        seen++;
      end
    end
    exp_l = density_ref(meas_exp_l);
    exp_r = density_ref(meas_exp_r);
    if (ones_l < exp_l - TOL || ones_l > exp_l + TOL) begin
      $display("[ERROR] %s_left: expected %0d +/- %0d ones, actual %0d",
               meas_name, exp_l, TOL, ones_l);
      errors++;
    end
    if (ones_r < exp_r - TOL || ones_r > exp_r + TOL) begin
      $display("[ERROR] %s_right: expected %0d +/- %0d ones, actual %0d",
               meas_name, exp_r, TOL, ones_r);
      errors++;
    end
    meas_go = 1'b0;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] v;
    int          vol_l;
    int          vol_r;
    int          sl;
    int          sr;
    int          changes;
    int          ticks;
    int          trans;
    int          exp_tr;
    logic        hold_l;
    logic        hold_r;
    int          divs [2];
    divs = '{0, 9};
    reset     = 1'b1;
    reg_req   = 1'b0;
    reg_op    = REG_READ;
    reg_addr  = REG_VOL_L;
    reg_wdata = '0;
    smp_req   = 1'b0;
    smp_left  = '0;
    smp_right = '0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    check_val("reset_outputs", 0, int'({reg_ack, smp_ack, i_dut.tick, left, right}));

    // register reset values and readback
    check_reg("reset_vol_l", REG_VOL_L, 64);
    check_reg("reset_vol_r", REG_VOL_R, 64);
    check_reg("reset_ctrl", REG_CTRL, 2);
    check_reg("reset_div", REG_DIV, 3);
    for (int i = 0; i < 4; i++) begin
      v = rand_bits(7);
      reg_write(REG_VOL_L, v[7:0]);
      check_reg($sformatf("rw_vol_l_%0d", i), REG_VOL_L, v > 64 ? 64 : int'(v));
      v = rand_bits(7);
      reg_write(REG_VOL_R, v[7:0]);
      check_reg($sformatf("rw_vol_r_%0d", i), REG_VOL_R, v > 64 ? 64 : int'(v));
      v = rand_bits(2);
      reg_write(REG_CTRL, v[7:0]);
      check_reg($sformatf("rw_ctrl_%0d", i), REG_CTRL, int'(v));
      v = rand_bits(8);
      reg_write(REG_DIV, v[7:0]);
      check_reg($sformatf("rw_div_%0d", i), REG_DIV, int'(v));
    end
    reg_write(REG_VOL_R, 8'd200);  // clamps
    check_reg("vol_clamp", REG_VOL_R, 64);
    reg_write(REG_VOL_L, 8'd64);
    reg_write(REG_CTRL, 8'd2);
    reg_write(REG_DIV, 8'(DIV_RUN));

    // bitstream density for random samples and volumes
    for (int t = 0; t < N_DENSITY; t++) begin
      v = rand_bits(7);
      vol_l = int'(v);
      v = rand_bits(7);
      vol_r = int'(v);
      reg_write(REG_VOL_L, 8'(vol_l));
      reg_write(REG_VOL_R, 8'(vol_r));
      sl = rand_sample();
      sr = rand_sample();
      smp_load(sl, sr);
      wait_ticks(SETTLE);
      meas_name  = $sformatf("density_%0d", t);
      meas_exp_l = scaled_ref(sl, vol_l > 64 ? 64 : vol_l, 1'b0);
      meas_exp_r = scaled_ref(sr, vol_r > 64 ? 64 : vol_r, 1'b0);
      meas_go    = 1'b1;
      wait (!meas_go);
      @(posedge clk);
      #2;
    end

    // silence toggles, first by mute then by a zero sample
    reg_write(REG_CTRL, 8'd3);
    wait_ticks(SETTLE);
    meas_name  = "mute_density";
    meas_exp_l = scaled_ref(sl, vol_l > 64 ? 64 : vol_l, 1'b1);
    meas_exp_r = scaled_ref(sr, vol_r > 64 ? 64 : vol_r, 1'b1);
    meas_go    = 1'b1;
    wait (!meas_go);
    check_toggle("mute_toggle", 32);
    smp_load(0, 0);
    reg_write(REG_CTRL, 8'd2);
    wait_ticks(SETTLE);
    check_toggle("zero_toggle", 32);

    // disabled modulator holds its outputs
    reg_write(REG_CTRL, 8'd0);
    hold_l  = left;
    hold_r  = right;
    changes = 0;
    ticks   = 0;
    repeat (200) begin
      @(negedge clk);
      if (left != hold_l || right != hold_r) changes++;
      if (i_dut.tick) ticks++;
    end
    check_val("enable_off_changes", 0, changes);
    check_val("enable_off_ticks", 0, ticks);
    @(posedge clk);
    #2;
    reg_write(REG_CTRL, 8'd2);
    hold_l = left;
    hold_r = right;
    wait_ticks(1);
    check_val("enable_on_left", int'(!hold_l), int'(left));
    check_val("enable_on_right", int'(!hold_r), int'(right));

    // transition rate follows the divider
    foreach (divs[k]) begin
      reg_write(REG_DIV, 8'(divs[k]));
      repeat (20) @(posedge clk);
      @(negedge clk);
      hold_l = left;
      trans  = 0;
      repeat (DIV_CLOCKS) begin
        @(negedge clk);
        if (left != hold_l) trans++;
        hold_l = left;
      end
      exp_tr = DIV_CLOCKS / (divs[k] + 1);
      if (trans < exp_tr - 1 || trans > exp_tr + 1) begin
        $display("[ERROR] div_%0d_transitions: expected %0d, actual %0d",
                 divs[k], exp_tr, trans);
        errors++;
      end
      @(posedge clk);
      #2;
    end

    $display("tb_audio_out finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/audio_pkg.sv
hdl/audio_reg_pkg.sv
hdl/audio_cfg_if.sv
hdl/audio_ctrl_regs.sv
hdl/sample_mixer.sv
hdl/sigma_delta_modulator.sv
hdl/audio_out_top.sv
sim/tb_audio_out.sv

// File: Makefile
TOP := tb_audio_out

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
